/* design/isa_pkg.sv */
`default_nettype none

package isa_pkg;

    // Major opcodes of the supported RV32I subset.
    typedef enum logic [6:0] {
        OP_NONE   = 7'b0000000,
        OP_IMM    = 7'b0010011,
        OP_REG    = 7'b0110011,
        OP_BRANCH = 7'b1100011
    } opcode_e;

    // ALU and branch funct3 codes.
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;
    localparam logic [2:0] F3_BEQ     = 3'b000;
    localparam logic [2:0] F3_BNE     = 3'b001;

    // Only funct7 value that changes an R-type op here.
    localparam logic [6:0] FUNCT7_SUB = 7'b0100000;

    typedef enum logic [2:0] {
        ALU_ADD    = 3'd0,
        ALU_SUB    = 3'd1,
        ALU_AND    = 3'd2,
        ALU_OR     = 3'd3,
        ALU_XOR    = 3'd4,
        ALU_PASS_B = 3'd5
    } alu_op_e;

    localparam int REG_ADDR_W = 5;

    // --------------------
    // Field positions, lsb of each field.
    // --------------------
    localparam int RD_LSB     = 7;
    localparam int FUNCT3_LSB = 12;
    localparam int RS1_LSB    = 15;
    localparam int RS2_LSB    = 20;
    localparam int FUNCT7_LSB = 25;

endpackage

`default_nettype wire

/* design/pipe_pkg.sv */
`default_nettype none

package pipe_pkg;

    localparam int DATA_W      = 32;
    localparam int INSTR_W     = 32;
    localparam int IMEM_DEPTH  = 64;
    localparam int IMEM_ADDR_W = 6;
    localparam int CNT_W       = 16;

    // Fetch to decode.
    typedef struct packed {
        logic               valid;
        logic [DATA_W-1:0]  pc;
        logic [INSTR_W-1:0] instr;
    } fetch_pkt_t;

    // Decode to execute.
    typedef struct packed {
        logic                           valid;
        logic [DATA_W-1:0]              pc;
        logic [DATA_W-1:0]              rs1_data;
        logic [DATA_W-1:0]              rs2_data;
        logic [isa_pkg::REG_ADDR_W-1:0] rs1_addr;
        logic [isa_pkg::REG_ADDR_W-1:0] rs2_addr;
        logic [isa_pkg::REG_ADDR_W-1:0] rd_addr;
        logic [DATA_W-1:0]              imm;
        isa_pkg::alu_op_e               alu_op;
        logic                           alu_src_imm;
        logic                           is_branch;
        logic                           branch_ne;
        logic                           reg_we;
    } exec_pkt_t;

    // Register write event.
    typedef struct packed {
        logic                           valid;
        logic [isa_pkg::REG_ADDR_W-1:0] rd;
        logic [DATA_W-1:0]              data;
    } wb_event_t;

    // PC override from branch resolution.
    typedef struct packed {
        logic              valid;
        logic [DATA_W-1:0] target;
    } redirect_t;

endpackage

`default_nettype wire

/* design/instr_fetch.sv */
`timescale 1ns/1ps
`default_nettype none

module instr_fetch (
    input  logic                             i_clk,
    input  logic                             i_arst,
    input  logic                             i_run,
    input  logic                             i_imem_we,
    input  logic [pipe_pkg::IMEM_ADDR_W-1:0] i_imem_addr,
    input  logic [pipe_pkg::INSTR_W-1:0]     i_imem_data,
    input  pipe_pkg::redirect_t              i_redirect,
    output pipe_pkg::fetch_pkt_t             o_fetch
);

    import pipe_pkg::*;

    logic [INSTR_W-1:0]     imem [IMEM_DEPTH];
    logic [IMEM_DEPTH-1:0]  imem_loaded;
    logic [DATA_W-1:0]      pc;
    logic [IMEM_ADDR_W-1:0] pc_word;
    logic [INSTR_W-1:0]     fetch_word;

    // Write port, open only while the core is idle.
    always_ff @(posedge i_clk) begin
        if (i_imem_we && !i_run) begin
            imem[i_imem_addr] <= i_imem_data;
        end
    end

    // Per-word loaded flags.
    // Words never written read back as zero.
    always_ff @(posedge i_clk or posedge i_arst) begin
        if (i_arst) begin
            imem_loaded <= '0;
        end else if (i_imem_we && !i_run) begin
            imem_loaded[i_imem_addr] <= 1'b1;
        end
    end

    assign pc_word    = pc[IMEM_ADDR_W+1:2];
    assign fetch_word = imem_loaded[pc_word] ? imem[pc_word] : '0;

    // Static not-taken, so only a redirect breaks the +4 stream.
    always_ff @(posedge i_clk or posedge i_arst) begin
        if (i_arst) begin
            pc <= '0;
        end else if (i_redirect.valid) begin
            pc <= i_redirect.target;
        end else if (i_run) begin
            pc <= pc + DATA_W'(4);
        end
    end

    // Fetch to decode register.
    always_ff @(posedge i_clk or posedge i_arst) begin
        if (i_arst) begin
            o_fetch <= '0;
        end else if (i_redirect.valid) begin
            // Wrong-path word.
            o_fetch <= '0;
        end else begin
            o_fetch.valid <= i_run;
            o_fetch.pc    <= pc;
            o_fetch.instr <= fetch_word;
        end
    end

endmodule

`default_nettype wire

/* design/reg_file.sv */
`timescale 1ns/1ps
`default_nettype none

module reg_file (
    input  logic                           i_clk,
    input  logic                           i_arst,
    input  logic [isa_pkg::REG_ADDR_W-1:0] i_rs1_addr,
    input  logic [isa_pkg::REG_ADDR_W-1:0] i_rs2_addr,
    input  pipe_pkg::wb_event_t            i_wb,
    output logic [pipe_pkg::DATA_W-1:0]    o_rs1_data,
    output logic [pipe_pkg::DATA_W-1:0]    o_rs2_data
);

    import isa_pkg::*;
    import pipe_pkg::*;

    // x1 to x31 only.
    logic [DATA_W-1:0] regs [1:31];

    always_ff @(posedge i_clk or posedge i_arst) begin
        if (i_arst) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (i_wb.valid && (i_wb.rd != '0)) begin
            regs[i_wb.rd] <= i_wb.data;
        end
    end

    // Read with write-through of the retiring value.
    function automatic logic [DATA_W-1:0] read_port(input logic [REG_ADDR_W-1:0] addr);
        if (addr == '0) begin
            return '0;
        end else if (i_wb.valid && (i_wb.rd == addr)) begin
            return i_wb.data;
        end
        return regs[addr];
    endfunction

    always_comb begin
        o_rs1_data = read_port(i_rs1_addr);
        o_rs2_data = read_port(i_rs2_addr);
    end

endmodule

`default_nettype wire

/* design/instr_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module instr_decode (
    input  logic                 i_clk,
    input  logic                 i_arst,
    input  pipe_pkg::fetch_pkt_t i_fetch,
    input  pipe_pkg::wb_event_t  i_wb,
    input  pipe_pkg::redirect_t  i_redirect,
    output pipe_pkg::exec_pkt_t  o_exec
);

    import isa_pkg::*;
    import pipe_pkg::*;

    logic [INSTR_W-1:0]    instr;
    opcode_e               opcode;
    logic [2:0]            funct3;
    logic [6:0]            funct7;
    logic [REG_ADDR_W-1:0] rs1_addr;
    logic [REG_ADDR_W-1:0] rs2_addr;
    logic [REG_ADDR_W-1:0] rd_addr;
    logic [DATA_W-1:0]     rs1_data;
    logic [DATA_W-1:0]     rs2_data;
    logic [DATA_W-1:0]     imm_i;
    logic [DATA_W-1:0]     imm_b;
    alu_op_e               alu_op;
    logic                  legal;
    exec_pkt_t             dec_pkt;

    // --------------------
    // Field extraction.
    // --------------------
    assign instr    = i_fetch.instr;
    assign funct3   = instr[FUNCT3_LSB +: 3];
    assign funct7   = instr[FUNCT7_LSB +: 7];
    assign rs1_addr = instr[RS1_LSB +: REG_ADDR_W];
    assign rs2_addr = instr[RS2_LSB +: REG_ADDR_W];
    assign rd_addr  = instr[RD_LSB +: REG_ADDR_W];

    assign imm_i = {{(DATA_W-12){instr[31]}}, instr[31:20]};
    assign imm_b = {{(DATA_W-13){instr[31]}}, instr[31], instr[7], instr[30:25],
                    instr[11:8], 1'b0};

    // Unknown major opcodes collapse to OP_NONE.
    always_comb begin
        case (instr[6:0])
            OP_IMM:    opcode = OP_IMM;
            OP_REG:    opcode = OP_REG;
            OP_BRANCH: opcode = OP_BRANCH;
            default:   opcode = OP_NONE;
        endcase
    end

    // ALU select and legality check.
    always_comb begin
        alu_op = ALU_PASS_B;
        legal  = 1'b0;
        case (opcode)
            OP_REG, OP_IMM: begin
                legal = 1'b1;
                case (funct3)
                    F3_ADD_SUB: begin
                        if ((opcode == OP_REG) && (funct7 == FUNCT7_SUB)) begin
                            alu_op = ALU_SUB;
                        end else begin
                            alu_op = ALU_ADD;
                        end
                    end
                    F3_XOR:  alu_op = ALU_XOR;
                    F3_OR:   alu_op = ALU_OR;
                    F3_AND:  alu_op = ALU_AND;
                    default: legal  = 1'b0;
                endcase
            end
            OP_BRANCH: legal = (funct3 == F3_BEQ) || (funct3 == F3_BNE);
            default:   legal = 1'b0;
        endcase
    end

    reg_file u_reg_file (
        .i_clk      (i_clk),
        .i_arst     (i_arst),
        .i_rs1_addr (rs1_addr),
        .i_rs2_addr (rs2_addr),
        .i_wb       (i_wb),
        .o_rs1_data (rs1_data),
        .o_rs2_data (rs2_data)
    );

    always_comb begin
        dec_pkt.valid       = i_fetch.valid && legal;
        dec_pkt.pc          = i_fetch.pc;
        dec_pkt.rs1_data    = rs1_data;
        dec_pkt.rs2_data    = rs2_data;
        dec_pkt.rs1_addr    = rs1_addr;
        dec_pkt.rs2_addr    = rs2_addr;
        dec_pkt.rd_addr     = rd_addr;
        dec_pkt.imm         = (opcode == OP_BRANCH) ? imm_b : imm_i;
        dec_pkt.alu_op      = alu_op;
        dec_pkt.alu_src_imm = (opcode == OP_IMM);
        dec_pkt.is_branch   = (opcode == OP_BRANCH);
        dec_pkt.branch_ne   = (funct3 == F3_BNE);
        // x0 targets never produce a write event.
        dec_pkt.reg_we      = (opcode != OP_BRANCH) && (rd_addr != '0);
    end

    // Decode to execute register.
    always_ff @(posedge i_clk or posedge i_arst) begin
        if (i_arst) begin
            o_exec <= '0;
        end else if (i_redirect.valid) begin
            o_exec <= '0;
        end else begin
            o_exec <= dec_pkt;
        end
    end

endmodule

`default_nettype wire

/* design/execute_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module execute_unit (
    input  logic                i_clk,
    input  logic                i_arst,
    input  pipe_pkg::exec_pkt_t i_exec,
    input  pipe_pkg::wb_event_t i_wb,
    output pipe_pkg::redirect_t o_redirect,
    output pipe_pkg::wb_event_t o_result,
    output logic                o_branch,
    output logic                o_mispred
);

    import isa_pkg::*;
    import pipe_pkg::*;

    logic [DATA_W-1:0] op_a;
    logic [DATA_W-1:0] rs2_fwd;
    logic [DATA_W-1:0] op_b;
    logic [DATA_W-1:0] alu_out;
    logic              operands_eq;
    logic              taken;

    // --------------------
    // Operand forwarding from retire.
    // --------------------
    assign op_a = (i_wb.valid && (i_wb.rd == i_exec.rs1_addr)) ? i_wb.data
                                                               : i_exec.rs1_data;
    assign rs2_fwd = (i_wb.valid && (i_wb.rd == i_exec.rs2_addr)) ? i_wb.data
                                                                  : i_exec.rs2_data;
    assign op_b = i_exec.alu_src_imm ? i_exec.imm : rs2_fwd;

    always_comb begin
        case (i_exec.alu_op)
            ALU_ADD:    alu_out = op_a + op_b;
            ALU_SUB:    alu_out = op_a - op_b;
            ALU_AND:    alu_out = op_a & op_b;
            ALU_OR:     alu_out = op_a | op_b;
            ALU_XOR:    alu_out = op_a ^ op_b;
            ALU_PASS_B: alu_out = op_b;
            default:    alu_out = op_b;
        endcase
    end

    // --------------------
    // Branch resolution.
    // --------------------
    // Not-taken is predicted, so any taken branch is a mispredict.
    assign operands_eq = (op_a == rs2_fwd);
    assign taken = i_exec.valid && i_exec.is_branch && (operands_eq ^ i_exec.branch_ne);

    assign o_redirect.valid  = taken;
    assign o_redirect.target = i_exec.pc + i_exec.imm;

    assign o_result.valid = i_exec.valid && i_exec.reg_we;
    assign o_result.rd    = i_exec.rd_addr;
    assign o_result.data  = alu_out;

    // Branch outcome register toward retire.
    always_ff @(posedge i_clk or posedge i_arst) begin
        if (i_arst) begin
            o_branch  <= 1'b0;
            o_mispred <= 1'b0;
        end else begin
            o_branch  <= i_exec.valid && i_exec.is_branch;
            o_mispred <= taken;
        end
    end

endmodule

`default_nettype wire

/* design/retire_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module retire_stage (
    input  logic                       i_clk,
    input  logic                       i_arst,
    input  pipe_pkg::wb_event_t        i_result,
    input  logic                       i_branch,
    input  logic                       i_mispred,
    output pipe_pkg::wb_event_t        o_wb,
    output logic [pipe_pkg::CNT_W-1:0] o_branch_count,
    output logic [pipe_pkg::CNT_W-1:0] o_mispred_count
);

    import pipe_pkg::*;

    // Write-back register.
    always_ff @(posedge i_clk or posedge i_arst) begin
        if (i_arst) begin
            o_wb <= '0;
        end else begin
            o_wb <= i_result;
        end
    end

    // Branch accuracy counters.
    always_ff @(posedge i_clk or posedge i_arst) begin
        if (i_arst) begin
            o_branch_count  <= '0;
            o_mispred_count <= '0;
        end else begin
            if (i_branch) begin
                o_branch_count <= o_branch_count + CNT_W'(1);
            end
            if (i_mispred) begin
                o_mispred_count <= o_mispred_count + CNT_W'(1);
            end
        end
    end

endmodule

`default_nettype wire

/* design/pipeline_core.sv */
`timescale 1ns/1ps
`default_nettype none

module pipeline_core (
    input  logic                             i_clk,
    input  logic                             i_arst,
    input  logic                             i_run,
    input  logic                             i_imem_we,
    input  logic [pipe_pkg::IMEM_ADDR_W-1:0] i_imem_addr,
    input  logic [pipe_pkg::INSTR_W-1:0]     i_imem_data,
    output pipe_pkg::wb_event_t              o_wb,
    output logic [pipe_pkg::CNT_W-1:0]       o_branch_count,
    output logic [pipe_pkg::CNT_W-1:0]       o_mispred_count
);

    import pipe_pkg::*;

    fetch_pkt_t fetch_pkt;
    exec_pkt_t  exec_pkt;
    redirect_t  redirect;
    wb_event_t  exec_result;
    logic       branch_done;
    logic       branch_mispred;

    // --------------------
    // Fetch.
    // --------------------
    instr_fetch u_fetch (
        .i_clk       (i_clk),
        .i_arst      (i_arst),
        .i_run       (i_run),
        .i_imem_we   (i_imem_we),
        .i_imem_addr (i_imem_addr),
        .i_imem_data (i_imem_data),
        .i_redirect  (redirect),
        .o_fetch     (fetch_pkt)
    );

    // --------------------
    // Decode and execute.
    // --------------------
    // Register file is written from the retire register.
    instr_decode u_decode (
        .i_clk      (i_clk),
        .i_arst     (i_arst),
        .i_fetch    (fetch_pkt),
        .i_wb       (o_wb),
        .i_redirect (redirect),
        .o_exec     (exec_pkt)
    );

    execute_unit u_execute (
        .i_clk      (i_clk),
        .i_arst     (i_arst),
        .i_exec     (exec_pkt),
        .i_wb       (o_wb),
        .o_redirect (redirect),
        .o_result   (exec_result),
        .o_branch   (branch_done),
        .o_mispred  (branch_mispred)
    );

    // --------------------
    // Retire.
    // --------------------
    retire_stage u_retire (
        .i_clk           (i_clk),
        .i_arst          (i_arst),
        .i_result        (exec_result),
        .i_branch        (branch_done),
        .i_mispred       (branch_mispred),
        .o_wb            (o_wb),
        .o_branch_count  (o_branch_count),
        .o_mispred_count (o_mispred_count)
    );

endmodule

`default_nettype wire

/* tests/pipeline_core_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module pipeline_core_checker (
    input logic                       i_clk,
    input logic                       i_arst,
    input pipe_pkg::wb_event_t        i_wb,
    input logic [pipe_pkg::CNT_W-1:0] i_branch_count,
    input logic [pipe_pkg::CNT_W-1:0] i_mispred_count
);

    // x0 is never a write-back target.
    wb_not_x0: assert property (@(posedge i_clk) disable iff (i_arst)
        i_wb.valid |-> (i_wb.rd != '0))
        else $error("write-back event targets x0");

    mispred_bounded: assert property (@(posedge i_clk) disable iff (i_arst)
        i_mispred_count <= i_branch_count)
        else $error("mispredict count above branch count");

    // Counters only move up.
    branch_count_up: assert property (@(posedge i_clk) disable iff (i_arst)
        i_branch_count >= $past(i_branch_count))
        else $error("branch count decreased");

    mispred_count_up: assert property (@(posedge i_clk) disable iff (i_arst)
        i_mispred_count >= $past(i_mispred_count))
        else $error("mispredict count decreased");

endmodule

bind pipeline_core pipeline_core_checker u_checker (
    .i_clk           (i_clk),
    .i_arst          (i_arst),
    .i_wb            (o_wb),
    .i_branch_count  (o_branch_count),
    .i_mispred_count (o_mispred_count)
);

`default_nettype wire

/* tests/pipeline_core_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module pipeline_core_tb;

    import isa_pkg::*;
    import pipe_pkg::*;

    localparam int PROG_LEN     = 27;
    localparam int DRAIN_CYCLES = 20;
    localparam int WATCHDOG_NS  = (PROG_LEN + 20) * 20 * 4;
    // Four branches run in section 4, two of them taken.
    localparam int EXP_BRANCHES = 4;
    localparam int EXP_TAKEN    = 2;

    typedef struct packed {
        logic [INSTR_W-1:0]    instr;
        logic                  writes;
        logic [REG_ADDR_W-1:0] rd;
        logic [DATA_W-1:0]     value;
        logic [2:0]            test;
    } prog_entry_t;

    logic                   i_clk = 1'b0;
    logic                   i_arst;
    logic                   i_run;
    logic                   i_imem_we;
    logic [IMEM_ADDR_W-1:0] i_imem_addr;
    logic [INSTR_W-1:0]     i_imem_data;
    wb_event_t              wb;
    logic [CNT_W-1:0]       branch_count;
    logic [CNT_W-1:0]       mispred_count;

    prog_entry_t prog [PROG_LEN];
    int          exp_idx [PROG_LEN];
    int          test_err [1:5];
    int          prog_len = 0;
    int          n_exp = 0;
    int          exp_pos = 0;
    int          pass_count = 0;
    int          fail_count = 0;
    logic        checking = 1'b0;
    prog_entry_t cur;

    pipeline_core uut (
        .i_clk           (i_clk),
        .i_arst          (i_arst),
        .i_run           (i_run),
        .i_imem_we       (i_imem_we),
        .i_imem_addr     (i_imem_addr),
        .i_imem_data     (i_imem_data),
        .o_wb            (wb),
        .o_branch_count  (branch_count),
        .o_mispred_count (mispred_count)
    );

    always #10 i_clk = ~i_clk;

    // --------------------
    // Instruction encoders.
    // --------------------
    function automatic logic [31:0] encode_itype(input logic [11:0] imm, input logic [4:0] rs1,
                                                 input logic [2:0] f3, input logic [4:0] rd);
        return {imm, rs1, f3, rd, OP_IMM};
    endfunction

    function automatic logic [31:0] encode_rtype(input logic [6:0] f7, input logic [4:0] rs2,
                                                 input logic [4:0] rs1, input logic [2:0] f3,
                                                 input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, OP_REG};
    endfunction

    // B-type offset is in bytes, bit 0 dropped.
    function automatic logic [31:0] encode_btype(input logic [12:0] imm, input logic [4:0] rs2,
                                                 input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OP_BRANCH};
    endfunction

    task automatic add_entry(input logic [31:0] instr, input logic writes, input logic [4:0] rd,
                             input logic [31:0] value, input logic [2:0] test);
        prog[prog_len] = '{instr, writes, rd, value, test};
        if (writes) begin
            exp_idx[n_exp] = prog_len;
            n_exp++;
        end
        prog_len++;
    endtask

    // Program in memory order, expected results worked out by hand.
    task automatic fill_program();
        // Independent ALU ops.
        add_entry(encode_itype(12'd5, 5'd0, F3_ADD_SUB, 5'd1), 1'b1, 5'd1, 32'd5, 3'd2);
        add_entry(encode_itype(12'hffd, 5'd0, F3_ADD_SUB, 5'd2), 1'b1, 5'd2, 32'hffff_fffd, 3'd2);
        add_entry(encode_itype(12'h0f0, 5'd0, F3_ADD_SUB, 5'd3), 1'b1, 5'd3, 32'h0000_00f0, 3'd2);
        add_entry(encode_itype(12'h0ff, 5'd0, F3_ADD_SUB, 5'd4), 1'b1, 5'd4, 32'h0000_00ff, 3'd2);
        add_entry(encode_rtype(7'd0, 5'd2, 5'd1, F3_ADD_SUB, 5'd5), 1'b1, 5'd5, 32'd2, 3'd2);
        add_entry(encode_rtype(FUNCT7_SUB, 5'd2, 5'd1, F3_ADD_SUB, 5'd6), 1'b1, 5'd6, 32'd8, 3'd2);
        add_entry(encode_rtype(7'd0, 5'd4, 5'd3, F3_AND, 5'd7), 1'b1, 5'd7, 32'h0000_00f0, 3'd2);
        add_entry(encode_rtype(7'd0, 5'd1, 5'd3, F3_OR, 5'd8), 1'b1, 5'd8, 32'h0000_00f5, 3'd2);
        add_entry(encode_rtype(7'd0, 5'd3, 5'd4, F3_XOR, 5'd9), 1'b1, 5'd9, 32'h0000_000f, 3'd2);
        // Dependent chain at distance one and two.
        add_entry(encode_itype(12'd10, 5'd1, F3_ADD_SUB, 5'd10), 1'b1, 5'd10, 32'd15, 3'd3);
        add_entry(encode_rtype(7'd0, 5'd10, 5'd10, F3_ADD_SUB, 5'd11), 1'b1, 5'd11, 32'd30, 3'd3);
        add_entry(encode_rtype(FUNCT7_SUB, 5'd10, 5'd11, F3_ADD_SUB, 5'd12), 1'b1, 5'd12, 32'd15,
                  3'd3);
        add_entry(encode_rtype(7'd0, 5'd11, 5'd12, F3_XOR, 5'd13), 1'b1, 5'd13, 32'd17, 3'd3);
        add_entry(encode_itype(12'd1, 5'd13, F3_ADD_SUB, 5'd13), 1'b1, 5'd13, 32'd18, 3'd3);
        // Taken BEQ and BNE, each skipping two words.
        add_entry(encode_btype(13'd12, 5'd12, 5'd10, F3_BEQ), 1'b0, 5'd0, 32'd0, 3'd4);
        add_entry(encode_itype(12'd99, 5'd0, F3_ADD_SUB, 5'd14), 1'b0, 5'd0, 32'd0, 3'd4);
        add_entry(encode_itype(12'd98, 5'd0, F3_ADD_SUB, 5'd15), 1'b0, 5'd0, 32'd0, 3'd4);
        add_entry(encode_btype(13'd12, 5'd2, 5'd1, F3_BNE), 1'b0, 5'd0, 32'd0, 3'd4);
        add_entry(encode_itype(12'd97, 5'd0, F3_ADD_SUB, 5'd14), 1'b0, 5'd0, 32'd0, 3'd4);
        add_entry(encode_itype(12'd96, 5'd0, F3_ADD_SUB, 5'd15), 1'b0, 5'd0, 32'd0, 3'd4);
        // Not-taken branches fall through.
        add_entry(encode_btype(13'd12, 5'd2, 5'd1, F3_BEQ), 1'b0, 5'd0, 32'd0, 3'd4);
        add_entry(encode_itype(12'd7, 5'd0, F3_ADD_SUB, 5'd14), 1'b1, 5'd14, 32'd7, 3'd4);
        add_entry(encode_btype(13'd12, 5'd13, 5'd14, F3_BEQ), 1'b0, 5'd0, 32'd0, 3'd4);
        add_entry(encode_itype(12'd1, 5'd14, F3_ADD_SUB, 5'd15), 1'b1, 5'd15, 32'd8, 3'd4);
        // x0 stays zero.
        add_entry(encode_itype(12'd55, 5'd0, F3_ADD_SUB, 5'd0), 1'b0, 5'd0, 32'd0, 3'd5);
        add_entry(encode_itype(12'd33, 5'd0, F3_ADD_SUB, 5'd16), 1'b1, 5'd16, 32'd33, 3'd5);
        add_entry(encode_rtype(7'd0, 5'd16, 5'd0, F3_ADD_SUB, 5'd17), 1'b1, 5'd17, 32'd33, 3'd5);
    endtask

    function automatic string describe_test(input int id);
        case (id)
            1:       return "reset and idle";
            2:       return "independent ALU ops";
            3:       return "dependent forwarding";
            4:       return "branches and counters";
            default: return "x0 writes and drain";
        endcase
    endfunction

    task automatic report_test(input int id);
        if (test_err[id] == 0) begin
            $display("test %0d, %s: ok", id, describe_test(id));
        end else begin
            $display("test %0d, %s: %0d errors", id, describe_test(id), test_err[id]);
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual, input int test);
        assert (actual == expected) begin
            pass_count++;
        end else begin
            $display("MISMATCH time=%0t signal=%s expected=0x%08h actual=0x%08h",
                     $time, name, expected, actual);
            fail_count++;
            test_err[test]++;
        end
    endtask

    task automatic check_idle();
        check_value("o_wb.valid", 32'd0, 32'(wb.valid), 1);
        check_value("o_branch_count", 32'd0, 32'(branch_count), 1);
        check_value("o_mispred_count", 32'd0, 32'(mispred_count), 1);
    endtask

    // Write-back monitor, sampled away from the active edge.
    always @(negedge i_clk) begin
        if (checking && wb.valid) begin
            assert (exp_pos < n_exp) else begin
                $display("ERROR at %0t: unexpected write-back to x%0d with data 0x%08h",
                         $time, wb.rd, wb.data);
                fail_count++;
                test_err[5]++;
            end
            if (exp_pos < n_exp) begin
                cur = prog[exp_idx[exp_pos]];
                check_value("o_wb.rd", 32'(cur.rd), 32'(wb.rd), int'(cur.test));
                check_value("o_wb.data", cur.value, wb.data, int'(cur.test));
                exp_pos++;
                if (cur.test < 3'd4 &&
                    (exp_pos == n_exp || prog[exp_idx[exp_pos]].test != cur.test)) begin
                    report_test(int'(cur.test));
                end
            end
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("ERROR: timeout, run did not finish within %0d ns", WATCHDOG_NS);
        $display("SIMULATION FAILED");
        $finish;
    end

    initial begin
        i_arst      = 1'b1;
        i_run       = 1'b0;
        i_imem_we   = 1'b0;
        i_imem_addr = '0;
        i_imem_data = '0;
        fill_program();

        repeat (10) begin
            @(negedge i_clk);
            check_idle();
        end
        @(posedge i_clk);
        #1;
        i_arst = 1'b0;

        // Load the program while the core is idle.
        for (int i = 0; i < prog_len; i++) begin
            i_imem_we   = 1'b1;
            i_imem_addr = IMEM_ADDR_W'(i);
            i_imem_data = prog[i].instr;
            @(negedge i_clk);
            check_idle();
            @(posedge i_clk);
            #1;
        end
        i_imem_we = 1'b0;
        report_test(1);

        i_run    = 1'b1;
        checking = 1'b1;
        while (exp_pos < n_exp) begin
            @(posedge i_clk);
        end
        repeat (DRAIN_CYCLES) @(posedge i_clk);

        @(negedge i_clk);
        check_value("o_branch_count", EXP_BRANCHES, 32'(branch_count), 4);
        check_value("o_mispred_count", EXP_TAKEN, 32'(mispred_count), 4);
        report_test(4);
        report_test(5);
        @(posedge i_clk);
        #1;
        i_run = 1'b0;

        $display("checks passed: %0d, checks failed: %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* build.f */
design/isa_pkg.sv
design/pipe_pkg.sv
design/instr_fetch.sv
design/reg_file.sv
design/instr_decode.sv
design/execute_unit.sv
design/retire_stage.sv
design/pipeline_core.sv
tests/pipeline_core_checker.sv
tests/pipeline_core_tb.sv

/* run.sh */
#!/bin/sh
# Compile and run the pipeline_core testbench with Verilator.
# Exit status is nonzero when the run reports a failure.

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal -f build.f \
    --top-module pipeline_core_tb -o sim_pipeline_core \
    && ./obj_dir/sim_pipeline_core > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or simulation exited with an error"; exit 1; }

cat sim.log
grep -q "SIMULATION FAILED" sim.log && exit 1 || exit 0
